/* project.f */
+incdir+src
src/video_pkg.sv
src/bram_pkg.sv
src/pixel_decimator.sv
src/pixel_cdc_fifo.sv
src/bram_pixel_writer.sv
src/rgb_capture_top.sv
tests/rgb_capture_asserts.sv
tests/tb_rgb_capture.sv

/* run_sim.sh */
#!/bin/sh
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_rgb_capture

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rgb_capture -f project.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* src/bram_pixel_writer.sv */
module bram_pixel_writer (
	input  logic                 clk125mhz_i,
	input  logic                 rst_n_i,
	input  logic                 empty_i,
	input  bram_pkg::fifo_word_t pop_word_i,
	output logic                 pop_o,
	output logic                 ena_o,
	output logic                 start_frame_o,
	output bram_pkg::bram_addr_t bramaddr_o,
	output video_pkg::color_t    rgb_r_o,
	output video_pkg::color_t    rgb_g_o,
	output video_pkg::color_t    rgb_b_o
);
	import bram_pkg::*;

	writer_state_t state;
	writer_state_t state_nxt;
	bram_addr_t next_addr;
	logic frame_flag;

	assign frame_flag = pop_word_i[$bits(fifo_word_t)-1];

	//////////////////////////////
	// fsm
	//////////////////////////////
	assign pop_o = (state == IDLE) && !empty_i;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (pop_o) begin
					state_nxt = WRITE;
				end
			end
			WRITE: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk125mhz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// one write per visit to WRITE
	assign ena_o = (state == WRITE);

	//////////////////////////////
	// address and frame start
	//////////////////////////////
	always_ff @(posedge clk125mhz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			start_frame_o <= 1'b0;
			bramaddr_o    <= '0;
			next_addr     <= '0;
		end else begin
			start_frame_o <= pop_o & frame_flag;
			if (pop_o) begin
				bramaddr_o <= frame_flag ? '0 : next_addr;
				next_addr  <= (frame_flag ? '0 : next_addr) + 1'b1;
			end
		end
	end

	always_ff @(posedge clk125mhz_i) begin
		if (pop_o) begin
			rgb_r_o <= pop_word_i[23:16];
			rgb_g_o <= pop_word_i[15:8];
			rgb_b_o <= pop_word_i[7:0];
		end
	end

endmodule

/* src/bram_pkg.sv */
package bram_pkg;

	//////////////////////////////
	// memory side
	//////////////////////////////

	// bram word address
	typedef logic [23:0] bram_addr_t;

	// frame start flag on top of one pixel
	typedef logic [$bits(video_pkg::pixel_t):0] fifo_word_t;

	// writer fsm
	typedef enum logic {
		IDLE,
		WRITE
	} writer_state_t;

endpackage

/* src/pixel_cdc_fifo.sv */
`include "video_cfg.svh"

module pixel_cdc_fifo (
	input  logic                 pclk_i,
	input  logic                 clk125mhz_i,
	input  logic                 rst_n_i,
	input  logic                 push_i,
	input  bram_pkg::fifo_word_t push_word_i,
	input  logic                 pop_i,
	output logic                 empty_o,
	output bram_pkg::fifo_word_t pop_word_o
);
	import bram_pkg::*;

	localparam int DEPTH = `PIX_FIFO_DEPTH;
	localparam int AW    = $clog2(DEPTH);

	// one extra bit tells a full lap from an empty one
	typedef logic [AW:0] ptr_t;

	fifo_word_t mem [DEPTH];

	ptr_t wptr_bin;
	ptr_t wptr_bin_nxt;
	ptr_t wptr_gray;
	ptr_t rptr_bin;
	ptr_t rptr_bin_nxt;
	ptr_t rptr_gray;
	ptr_t wq1_gray;
	ptr_t wq2_gray;

	function automatic ptr_t bin2gray(input ptr_t bin);
		return bin ^ (bin >> 1);
	endfunction

	//////////////////////////////
	// write side, pclk
	//////////////////////////////
	assign wptr_bin_nxt = wptr_bin + ptr_t'(push_i);

	always_ff @(posedge pclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wptr_bin  <= '0;
			wptr_gray <= '0;
		end else begin
			wptr_bin  <= wptr_bin_nxt;
			wptr_gray <= bin2gray(wptr_bin_nxt);
		end
	end

	always_ff @(posedge pclk_i) begin
		if (push_i) begin
			mem[wptr_bin[AW-1:0]] <= push_word_i;
		end
	end

	//////////////////////////////
	// read side, clk125MHz
	//////////////////////////////

	// two flop sync of the write pointer
	always_ff @(posedge clk125mhz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wq1_gray <= '0;
			wq2_gray <= '0;
		end else begin
			wq1_gray <= wptr_gray;
			wq2_gray <= wq1_gray;
		end
	end

	assign rptr_bin_nxt = rptr_bin + ptr_t'(pop_i & ~empty_o);

	always_ff @(posedge clk125mhz_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rptr_bin  <= '0;
			rptr_gray <= '0;
		end else begin
			rptr_bin  <= rptr_bin_nxt;
			rptr_gray <= bin2gray(rptr_bin_nxt);
		end
	end

	assign empty_o = (rptr_gray == wq2_gray);

	// read ahead, head entry always on the output
	assign pop_word_o = mem[rptr_bin[AW-1:0]];

endmodule

/* src/pixel_decimator.sv */
`include "video_cfg.svh"

module pixel_decimator (
	input  logic                 pclk_i,
	input  logic                 rst_n_i,
	input  logic                 hsync_i,
	input  logic                 vsync_i,
	input  logic                 vde_i,
	input  video_pkg::pixel_t    pdata_i,
	output logic                 push_o,
	output bram_pkg::fifo_word_t push_word_o
);
	import video_pkg::*;

	localparam int unsigned IN_W  = `VID_IN_WIDTH;
	localparam int unsigned IN_H  = `VID_IN_HEIGHT;
	localparam int unsigned OUT_W = `VID_OUT_WIDTH;
	localparam int unsigned OUT_H = `VID_OUT_HEIGHT;

	logic hsync_q;
	logic vsync_q;
	logic vde_q;
	logic hsync_rise;
	logic vsync_rise;
	logic vde_fall;

	col_cnt_t col_cnt;
	col_cnt_t col_acc;
	row_cnt_t row_cnt;
	row_cnt_t row_acc;
	logic [10:0] col_sum;
	logic [10:0] row_sum;
	logic col_wrap;
	logic row_wrap;
	logic keep;
	logic sof_pending;

	//////////////////////////////
	// sync edges
	//////////////////////////////
	assign hsync_rise = hsync_i & ~hsync_q;
	assign vsync_rise = vsync_i & ~vsync_q;
	assign vde_fall   = vde_q & ~vde_i;

	//////////////////////////////
	// scaling rule
	//////////////////////////////
	assign col_sum  = {1'b0, col_acc} + 11'(OUT_W);
	assign row_sum  = {1'b0, row_acc} + 11'(OUT_H);
	assign col_wrap = (col_sum >= 11'(IN_W));
	assign row_wrap = (row_sum >= 11'(IN_H));

	// pixels past the nominal frame size are never kept
	assign keep = vde_i & ~vsync_rise & col_wrap & row_wrap &
		(col_cnt < col_cnt_t'(IN_W)) & (row_cnt < row_cnt_t'(IN_H));

	always_ff @(posedge pclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hsync_q     <= 1'b0;
			vsync_q     <= 1'b0;
			vde_q       <= 1'b0;
			col_cnt     <= '0;
			col_acc     <= '0;
			row_cnt     <= '0;
			row_acc     <= '0;
			sof_pending <= 1'b1;
			push_o      <= 1'b0;
		end else begin
			hsync_q <= hsync_i;
			vsync_q <= vsync_i;
			vde_q   <= vde_i;
			push_o  <= keep;
			if (vsync_rise) begin
				col_cnt     <= '0;
				col_acc     <= '0;
				row_cnt     <= '0;
				row_acc     <= '0;
				sof_pending <= 1'b1;
			end else begin
				if (keep) begin
					sof_pending <= 1'b0;
				end
				// column state restarts at every line boundary
				if (hsync_rise || vde_fall) begin
					col_cnt <= '0;
					col_acc <= '0;
				end else if (vde_i) begin
					if (col_cnt < col_cnt_t'(IN_W)) begin
						col_cnt <= col_cnt + 1'b1;
					end
					col_acc <= col_cnt_t'(col_wrap ? col_sum - 11'(IN_W) : col_sum);
				end
				// row steps once per active line
				if (vde_fall) begin
					if (row_cnt < row_cnt_t'(IN_H)) begin
						row_cnt <= row_cnt + 1'b1;
					end
					row_acc <= row_cnt_t'(row_wrap ? row_sum - 11'(IN_H) : row_sum);
				end
			end
		end
	end

	always_ff @(posedge pclk_i) begin
		if (keep) begin
			push_word_o <= {sof_pending, pdata_i};
		end
	end

endmodule

/* src/rgb_capture_top.sv */
module rgb_capture_top (
	input  logic                 pclk_i,
	input  logic                 clk125mhz_i,
	input  logic                 rst_n_i,
	input  logic                 hsync_i,
	input  logic                 vsync_i,
	input  logic                 vde_i,
	input  video_pkg::pixel_t    pdata_i,
	output logic                 ena_o,
	output logic                 start_frame_o,
	output bram_pkg::bram_addr_t bramaddr_o,
	output video_pkg::color_t    rgb_r_o,
	output video_pkg::color_t    rgb_g_o,
	output video_pkg::color_t    rgb_b_o
);
	import bram_pkg::*;

	logic push;
	fifo_word_t push_word;
	logic pop;
	logic empty;
	fifo_word_t pop_word;

	//////////////////////////////
	// pclk side
	//////////////////////////////
	pixel_decimator i_pixel_decimator (
		.pclk_i      (pclk_i),
		.rst_n_i     (rst_n_i),
		.hsync_i     (hsync_i),
		.vsync_i     (vsync_i),
		.vde_i       (vde_i),
		.pdata_i     (pdata_i),
		.push_o      (push),
		.push_word_o (push_word)
	);

	// crossing into clk125MHz
	pixel_cdc_fifo i_pixel_cdc_fifo (
		.pclk_i      (pclk_i),
		.clk125mhz_i (clk125mhz_i),
		.rst_n_i     (rst_n_i),
		.push_i      (push),
		.push_word_i (push_word),
		.pop_i       (pop),
		.empty_o     (empty),
		.pop_word_o  (pop_word)
	);

	//////////////////////////////
	// clk125MHz side
	//////////////////////////////
	bram_pixel_writer i_bram_pixel_writer (
		.clk125mhz_i   (clk125mhz_i),
		.rst_n_i       (rst_n_i),
		.empty_i       (empty),
		.pop_word_i    (pop_word),
		.pop_o         (pop),
		.ena_o         (ena_o),
		.start_frame_o (start_frame_o),
		.bramaddr_o    (bramaddr_o),
		.rgb_r_o       (rgb_r_o),
		.rgb_g_o       (rgb_g_o),
		.rgb_b_o       (rgb_b_o)
	);

endmodule

/* src/video_cfg.svh */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

//////////////////////////////
// input frame, active area
//////////////////////////////
`define VID_IN_WIDTH   720
`define VID_IN_HEIGHT  480

//////////////////////////////
// output frame after scaling
//////////////////////////////
`define VID_OUT_WIDTH  320
`define VID_OUT_HEIGHT 240

// crossing fifo entries, power of two
`define PIX_FIFO_DEPTH 16

`endif

/* src/video_pkg.sv */
package video_pkg;

	//////////////////////////////
	// pixel data
	//////////////////////////////

	// red in the top byte, then green, then blue
	typedef logic [23:0] pixel_t;

	// one colour channel
	typedef logic [7:0] color_t;

	//////////////////////////////
	// frame position counters
	//////////////////////////////

	// input column, up to 1023
	typedef logic [9:0] col_cnt_t;

	// input row, up to 1023
	typedef logic [9:0] row_cnt_t;

endpackage

/* tests/rgb_capture_asserts.sv */
module rgb_capture_asserts (
	input logic                 clk125mhz_i,
	input logic                 rst_n_i,
	input logic                 ena_o,
	input logic                 start_frame_o,
	input bram_pkg::bram_addr_t bramaddr_o,
	input logic                 pop_i,
	input logic                 empty_i
);
	timeunit 1ns;
	timeprecision 1ps;

	//////////////////////////////
	// writer outputs
	//////////////////////////////

	// one write per pixel
	ena_single: assert property (@(posedge clk125mhz_i) disable iff (!rst_n_i)
		ena_o |=> !ena_o)
		else $error("ena_o high for two cycles in a row");

	sof_at_zero: assert property (@(posedge clk125mhz_i) disable iff (!rst_n_i)
		start_frame_o |-> (ena_o && bramaddr_o == '0))
		else $error("start_frame_o without a write to address 0");

	//////////////////////////////
	// fifo read side
	//////////////////////////////
	pop_not_empty: assert property (@(posedge clk125mhz_i) disable iff (!rst_n_i)
		pop_i |-> !empty_i)
		else $error("pop while the fifo is empty");

endmodule

/* tests/tb_rgb_capture.sv */
`include "video_cfg.svh"

module tb_rgb_capture;
	timeunit 1ns;
	timeprecision 1ps;

	import video_pkg::*;
	import bram_pkg::*;

	localparam int IN_W      = `VID_IN_WIDTH;
	localparam int IN_H      = `VID_IN_HEIGHT;
	localparam int OUT_W     = `VID_OUT_WIDTH;
	localparam int OUT_H     = `VID_OUT_HEIGHT;
	localparam int FRAME_PIX = `VID_OUT_WIDTH * `VID_OUT_HEIGHT;

	logic pclk;
	logic clk125mhz;
	logic rst_n;
	logic hsync;
	logic vsync;
	logic vde;
	pixel_t pdata;
	logic ena;
	logic start_frame;
	bram_addr_t bramaddr;
	color_t rgb_r;
	color_t rgb_g;
	color_t rgb_b;

	// reference model state
	pixel_t exp_pix[$];
	bram_addr_t exp_addr[$];
	logic exp_flag[$];
	bram_addr_t model_addr;
	logic sof_due;

	logic [31:0] lfsr_state;
	int err_cnt;
	int write_cnt;
	int sof_cnt;
	int test_cnt;
	int test_fail;
	bram_addr_t last_addr;

	rgb_capture_top i_rgb_capture_top (
		.pclk_i        (pclk),
		.clk125mhz_i   (clk125mhz),
		.rst_n_i       (rst_n),
		.hsync_i       (hsync),
		.vsync_i       (vsync),
		.vde_i         (vde),
		.pdata_i       (pdata),
		.ena_o         (ena),
		.start_frame_o (start_frame),
		.bramaddr_o    (bramaddr),
		.rgb_r_o       (rgb_r),
		.rgb_g_o       (rgb_g),
		.rgb_b_o       (rgb_b)
	);

	bind rgb_capture_top rgb_capture_asserts i_rgb_capture_asserts (
		.clk125mhz_i   (clk125mhz_i),
		.rst_n_i       (rst_n_i),
		.ena_o         (ena_o),
		.start_frame_o (start_frame_o),
		.bramaddr_o    (bramaddr_o),
		.pop_i         (pop),
		.empty_i       (empty)
	);

	initial begin
		pclk = 1'b0;
		forever #20 pclk = ~pclk;
	end

	// offset so no edge meets a pclk edge
	initial begin
		clk125mhz = 1'b0;
		#1;
		forever #4 clk125mhz = ~clk125mhz;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic pixel_t rand_pixel();
		pixel_t pix;
		pix = '0;
		for (int b = 0; b < $bits(pixel_t); b++) begin
			pix = {pix[22:0], lfsr_step()};
		end
		return pix;
	endfunction

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s exp %06h got %06h", $time, name, exp, got);
		end
	endtask

	task automatic check_addr(input string name, input bram_addr_t got, input bram_addr_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s exp %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s exp %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic drive(input logic hs, input logic vs, input logic de, input pixel_t data);
		@(negedge pclk);
		hsync = hs;
		vsync = vs;
		vde   = de;
		pdata = data;
	endtask

	task automatic expect_pixel(input pixel_t pix);
		if (sof_due) begin
			model_addr = '0;
		end else begin
			model_addr = model_addr + 1'b1;
		end
		exp_pix.push_back(pix);
		exp_addr.push_back(model_addr);
		exp_flag.push_back(sof_due);
		sof_due = 1'b0;
	endtask

	//////////////////////////////
	// output monitor
	//////////////////////////////
	always @(negedge clk125mhz) begin
		if (ena) begin
			write_cnt++;
			last_addr = bramaddr;
			if (start_frame) begin
				sof_cnt++;
			end
			if (exp_pix.size() == 0) begin
				err_cnt++;
				$display("unexpected write at address %0d with no pixel expected", bramaddr);
			end else begin
				check_pixel("rgb_r_o/rgb_g_o/rgb_b_o", {rgb_r, rgb_g, rgb_b}, exp_pix.pop_front());
				check_addr("bramaddr_o", bramaddr, exp_addr.pop_front());
				check_flag("start_frame_o", start_frame, exp_flag.pop_front());
			end
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	task automatic send_line(input logic row_keep);
		int col_acc;
		pixel_t pix;
		int i;
		col_acc = 0;
		// blanking with junk data and an hsync pulse
		for (i = 0; i < 16; i++) begin
			drive(i >= 2 && i < 6, 1'b0, 1'b0, rand_pixel());
		end
		for (i = 0; i < IN_W; i++) begin
			pix = rand_pixel();
			col_acc += OUT_W;
			if (col_acc >= IN_W) begin
				col_acc -= IN_W;
				if (row_keep) begin
					expect_pixel(pix);
				end
			end
			drive(1'b0, 1'b0, 1'b1, pix);
		end
	endtask

	task automatic send_frame();
		int row_acc;
		logic row_keep;
		int i;
		sof_due = 1'b1;
		row_acc = 0;
		for (i = 0; i < 8; i++) begin
			drive(1'b0, i >= 2 && i < 6, 1'b0, rand_pixel());
		end
		for (i = 0; i < IN_H; i++) begin
			row_acc += OUT_H;
			row_keep = (row_acc >= IN_H);
			if (row_keep) begin
				row_acc -= IN_H;
			end
			send_line(row_keep);
		end
		for (i = 0; i < 16; i++) begin
			drive(1'b0, 1'b0, 1'b0, rand_pixel());
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			test_fail++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_reset();
		int errs_before;
		int i;
		errs_before = err_cnt;
		write_cnt = 0;
		for (i = 0; i < 4; i++) begin
			@(negedge pclk);
			check_flag("ena_o", ena, 1'b0);
			check_flag("start_frame_o", start_frame, 1'b0);
			check_addr("bramaddr_o", bramaddr, '0);
		end
		rst_n = 1'b1;
		for (i = 0; i < 20; i++) begin
			drive(1'b0, 1'b0, 1'b0, rand_pixel());
			check_flag("ena_o", ena, 1'b0);
		end
		check_addr("write count", bram_addr_t'(write_cnt), '0);
		report_test("reset", errs_before);
	endtask

	task automatic test_frame(input string name);
		int errs_before;
		int i;
		errs_before = err_cnt;
		write_cnt = 0;
		sof_cnt = 0;
		send_frame();
		for (i = 0; i < 2000 && exp_pix.size() != 0; i++) begin
			@(negedge clk125mhz);
		end
		if (exp_pix.size() != 0) begin
			err_cnt++;
			$display("timeout: %0d expected pixels were never written", exp_pix.size());
		end
		// room for any stray late write
		repeat (40) @(negedge clk125mhz);
		check_addr("write count", bram_addr_t'(write_cnt), bram_addr_t'(FRAME_PIX));
		check_addr("frame start count", bram_addr_t'(sof_cnt), bram_addr_t'(1));
		check_addr("last bramaddr_o", last_addr, bram_addr_t'(FRAME_PIX - 1));
		report_test(name, errs_before);
	endtask

	initial begin
		rst_n = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		vde = 1'b0;
		pdata = '0;
		lfsr_state = 32'd67594;
		err_cnt = 0;
		write_cnt = 0;
		sof_cnt = 0;
		test_cnt = 0;
		test_fail = 0;
		model_addr = '0;
		sof_due = 1'b1;
		last_addr = '0;
		test_reset();
		test_frame("full frame");
		test_frame("second frame");
		$display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
